/* logic/displayPkg.sv */
package displayPkg;

   // Screen codes, the message the controller wants on the LCD
   localparam logic [2:0] screenNormal = 3'd0; // Effect NORMAL
   localparam logic [2:0] screenEcho = 3'd1; // Effect ECHO
   localparam logic [2:0] screenTremolo = 3'd2; // Effect TREMOLO
   localparam logic [2:0] screenReverb = 3'd3; // Effect REVERB
   localparam logic [2:0] screenSoft = 3'd4; // Effect SOFT_CLIPPING
   localparam logic [2:0] screenNone = 3'd6; // Nothing written yet
   localparam logic [2:0] screenListen = 3'd7; // Radio is receiving

   // Walkie-talkie mode as seen on talkieState
   localparam logic talkListen = 1'b0; // Receiving, show LISTENING
   localparam logic talkTalk = 1'b1; // Transmitting, show the effect name

   // I2C master states, read by the controller
   localparam logic [2:0] i2cBegins = 3'd0; // START condition
   localparam logic [2:0] i2cSend = 3'd1; // Shifting out eight bits
   localparam logic [2:0] i2cAck = 3'd2; // Ninth clock, slave answers
   localparam logic [2:0] i2cWait = 3'd3; // One cycle for the next byte to settle
   localparam logic [2:0] i2cEnds = 3'd4; // STOP condition
   localparam logic [2:0] i2cOff = 3'd5; // Bus idle

   localparam int sclHalfCycles = 4; // clk cycles per SCL half period
   localparam logic [6:0] lcdI2cAddr = 7'h27; // PCF8574 backpack with A2..A0 high
   localparam int maxNibbles = 32; // Depth of every message in the table
   localparam logic [5:0] nibbleEnd = 6'h3F; // Marks the end of a message

   // One PCF8574 output byte, seen raw by the I2C master and as LCD pins elsewhere
   typedef union packed {
      logic [7:0] raw; // Byte on the wire, MSB first
      struct packed {
         logic [3:0] data; // DB7..DB4 of the LCD
         logic led; // Backlight enable
         logic en; // LCD enable strobe
         logic rw; // Read not write, never set here
         logic rs; // High for character data, low for instructions
      } pins;
   } lcdByte_u;

endpackage

/* logic/i2cByteMaster.sv */
`timescale 1ns/1ns
module i2cByteMaster
   import displayPkg::*;
(
   input logic clk,
   input logic rst,
   input logic trans, // Controller wants the bus
   input lcdByte_u lcdByte, // Next data byte
   input logic sdaIn, // Resolved SDA line
   output logic scl, // SCL, high means released
   output logic sdaLow, // Pull SDA low
   output logic [2:0] i2cState, // Current state, read by the controller
   output logic ready, // Data byte acknowledged
   output logic commsError // Byte not acknowledged
);

   logic [2:0] state;
   logic [2:0] phase; // Position inside one SCL period, low half first
   logic [2:0] bitCnt; // Bits still to send after the current one
   logic [7:0] shiftReg; // Byte on its way out, MSB first
   logic isAddr; // Byte in flight is the address
   logic nack; // SDA was high at the ninth clock
   logic midLow; // Middle of the SCL low half, SDA may change
   logic midHigh; // Middle of the SCL high half, SDA is sampled
   logic bitEnd; // Last cycle of the SCL period

   assign midLow = phase == 3'(sclHalfCycles / 2);
   assign midHigh = phase == 3'(sclHalfCycles + sclHalfCycles / 2);
   assign bitEnd = phase == 3'(2 * sclHalfCycles - 1);
   assign i2cState = state;

   // Both pulses come in the last cycle of the ninth clock
   assign ready = (state == i2cAck) && bitEnd && !nack && !isAddr;
   assign commsError = (state == i2cAck) && bitEnd && nack;

   always_comb begin
      case (state)
         i2cOff, i2cBegins: scl = 1'b1; // START happens with SCL high
         i2cWait: scl = 1'b0;
         default: scl = phase >= 3'(sclHalfCycles);
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= i2cOff;
         phase <= 3'd0;
         bitCnt <= 3'd0;
         isAddr <= 1'b0;
         nack <= 1'b0;
         sdaLow <= 1'b0; // Bus released
      end else begin
         if (bitEnd || state == i2cOff || state == i2cWait) begin
            phase <= 3'd0;
         end else begin
            phase <= phase + 3'd1;
         end
         case (state)
            i2cOff: begin
               sdaLow <= 1'b0;
               if (trans) state <= i2cBegins;
            end
            i2cBegins: begin
               if (midLow) sdaLow <= 1'b1; // SDA falls while SCL is high
               if (bitEnd) begin
                  state <= i2cSend;
                  bitCnt <= 3'd7;
                  isAddr <= 1'b1;
               end
            end
            i2cSend: begin
               if (midLow) sdaLow <= ~shiftReg[7];
               if (bitEnd) begin
                  if (bitCnt == 3'd0) state <= i2cAck;
                  bitCnt <= bitCnt - 3'd1;
               end
            end
            i2cAck: begin
               if (midLow) sdaLow <= 1'b0; // Let the slave drive SDA
               if (midHigh) nack <= sdaIn;
               if (bitEnd) begin
                  if (nack) begin
                     state <= i2cEnds;
                  end else if (isAddr) begin
                     state <= i2cSend; // First data byte goes straight out
                     bitCnt <= 3'd7;
                     isAddr <= 1'b0;
                  end else begin
                     state <= i2cWait;
                  end
               end
            end
            i2cWait: begin
               bitCnt <= 3'd7;
               state <= trans ? i2cSend : i2cEnds; // Controller has answered ready by now
            end
            i2cEnds: begin
               if (midLow) sdaLow <= 1'b1;
               if (midHigh) sdaLow <= 1'b0; // SDA rises while SCL is high
               if (bitEnd) state <= i2cOff;
            end
            default: state <= i2cOff;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == i2cBegins && bitEnd) begin
         shiftReg <= {lcdI2cAddr, 1'b0}; // Address with write bit
      end else if ((state == i2cAck && bitEnd && isAddr) || state == i2cWait) begin
         shiftReg <= lcdByte.raw;
      end else if (state == i2cSend && bitEnd) begin
         shiftReg <= {shiftReg[6:0], 1'b0};
      end
   end

endmodule

/* logic/lcdDisplayCtrl.sv */
`timescale 1ns/1ns
module lcdDisplayCtrl
   import displayPkg::*;
(
   input logic clk,
   input logic rst,
   input logic talkieState, // Listening or talking
   input logic [2:0] currentEffect, // Active audio effect while talking
   input logic [2:0] i2cState, // State of the I2C master
   input logic ready, // Data byte was acknowledged
   input logic commsError, // A byte was not acknowledged
   input logic [5:0] nibble, // Table entry at nibbleIdx
   output logic [2:0] screenSel, // Screen the table should read
   output logic initSel, // Table returns the power-up sequence
   output logic [4:0] nibbleIdx, // Table address
   output logic trans, // Keep the I2C transfer going
   output lcdByte_u lcdByte // Byte the master sends next
);

   logic [2:0] desired; // Screen the radio state asks for
   logic [2:0] shown; // Screen last written without error
   logic [2:0] nextScreen; // Screen derived from the inputs right now
   logic initPending; // Power-up sequence has not gone through yet
   logic [4:0] byteIdx; // Table index of the byte in lcdByte
   logic startSend; // Begin a new message this cycle
   logic lastByte; // Byte just acknowledged was the final one
   logic loadByte; // Capture the table entry into lcdByte

   assign screenSel = desired;
   assign initSel = initPending;
   // Idle reads entry 0 for the first byte, busy reads one ahead of lcdByte
   assign nibbleIdx = trans ? byteIdx + 5'd1 : 5'd0;

   always_comb begin
      nextScreen = (talkieState == talkListen) ? screenListen : currentEffect;
      startSend = !trans && (i2cState == i2cOff) && (initPending || desired != shown);
      // The next entry ends the message, or the table is used up
      lastByte = (byteIdx == 5'(maxNibbles - 1)) || (nibble == nibbleEnd);
      loadByte = startSend || (trans && ready && !lastByte);
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         desired <= screenNone;
         shown <= screenNone; // Forces the first message after init
         initPending <= 1'b1;
         trans <= 1'b0;
         byteIdx <= 5'd0;
      end else if (!trans) begin
         if (startSend) begin
            trans <= 1'b1; // Master leaves i2cOff on this
            byteIdx <= 5'd0;
         end else begin
            desired <= nextScreen; // Inputs are only sampled while idle
         end
      end else if (commsError) begin
         trans <= 1'b0; // Shown screen stays old so the message repeats
         byteIdx <= 5'd0;
      end else if (ready) begin
         if (lastByte) begin
            trans <= 1'b0; // Master sends STOP after its wait cycle
            byteIdx <= 5'd0;
            if (initPending) begin
               initPending <= 1'b0;
            end else begin
               shown <= desired;
            end
         end else begin
            byteIdx <= byteIdx + 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (loadByte) begin
         lcdByte.pins.data <= nibble[5:2];
         lcdByte.pins.led <= 1'b1; // Backlight stays on
         lcdByte.pins.en <= 1'b1; // Enable high while the nibble is on the bus
         lcdByte.pins.rw <= nibble[1];
         lcdByte.pins.rs <= nibble[0];
      end
   end

endmodule

/* logic/lcdMessageRom.sv */
`timescale 1ns/1ns
module lcdMessageRom
   import displayPkg::*;
(
   input logic [2:0] screenSel, // Screen whose text is requested
   input logic initSel, // High selects the power-up sequence instead
   input logic [4:0] nibbleIdx, // Position in the message
   output logic [5:0] nibble // DB7..DB4, rw, rs
);

   logic [3:0] cmdSlot; // Byte of the message this nibble comes from
   logic [3:0] cmdPick; // Row of the instruction list below
   logic [7:0] cmdByte; // Instruction byte for the current slot
   logic cmdValid; // Slot holds an instruction rather than a character
   logic [3:0] charIdx; // Character number counted from the left
   logic [3:0] charPos; // Same character counted from the right end of text
   logic [103:0] text; // Screen text right aligned, 13 characters at most
   logic [3:0] textLen; // Number of characters in text
   logic [7:0] charByte; // ASCII code of the current character

   assign cmdSlot = nibbleIdx[4:1]; // Two nibbles per byte, high one first
   assign charIdx = cmdSlot - 4'd3; // Characters follow the three header commands
   assign charPos = textLen - 4'd1 - charIdx;
   assign charByte = text[{charPos, 3'b000} +: 8];

   // Init runs the whole list, a normal message only its last three rows
   assign cmdPick = initSel ? cmdSlot : cmdSlot + 4'd3;
   assign cmdValid = initSel ? (cmdSlot < 4'd6) : (cmdSlot < 4'd3);

   always_comb begin
      case (cmdPick)
         4'd0: cmdByte = 8'h20; // Function set, switch to 4-bit bus
         4'd1: cmdByte = 8'h28; // 4-bit bus, two lines, 5x8 font
         4'd2: cmdByte = 8'h0E; // Display on with cursor
         4'd3: cmdByte = 8'h01; // Clear display
         4'd4: cmdByte = 8'h06; // Entry mode, cursor moves right
         4'd5: cmdByte = 8'h02; // Return home
         default: cmdByte = 8'h00;
      endcase
   end

   always_comb begin
      case (screenSel)
         screenNormal: begin
            text = 104'("NORMAL");
            textLen = 4'd6;
         end
         screenEcho: begin
            text = 104'("ECHO");
            textLen = 4'd4;
         end
         screenTremolo: begin
            text = 104'("TREMOLO");
            textLen = 4'd7;
         end
         screenReverb: begin
            text = 104'("REVERB");
            textLen = 4'd6;
         end
         screenSoft: begin
            text = 104'("SOFT_CLIPPING"); // Fills all 32 entries
            textLen = 4'd13;
         end
         screenListen: begin
            text = 104'("LISTENING");
            textLen = 4'd9;
         end
         default: begin
            text = '0; // Unused codes only clear the screen
            textLen = 4'd0;
         end
      endcase
   end

   always_comb begin
      if (cmdValid) begin
         nibble = {(nibbleIdx[0] ? cmdByte[3:0] : cmdByte[7:4]), 2'b00}; // rs low for commands
      end else if (!initSel && charIdx < textLen) begin
         nibble = {(nibbleIdx[0] ? charByte[3:0] : charByte[7:4]), 2'b01}; // rs high for data
      end else begin
         nibble = nibbleEnd; // Past the end of this message
      end
   end

endmodule

/* logic/walkieDisplay.sv */
`timescale 1ns/1ns
module walkieDisplay
   import displayPkg::*;
(
   input logic clk,
   input logic rst,
   input logic talkieState, // Listening or talking
   input logic [2:0] currentEffect, // Audio effect in use
   input logic sdaIn, // SDA as seen on the bus
   output logic scl, // Open-drain SCL
   output logic sdaLow // Pulls SDA low when high
);

   logic [2:0] screenSel; // Controller picks the message
   logic initSel;
   logic [4:0] nibbleIdx;
   logic [5:0] nibble; // Table answer
   logic trans;
   lcdByte_u lcdByte;
   logic [2:0] i2cState;
   logic ready;
   logic commsError;

   lcdDisplayCtrl lcdDisplayCtrl_inst (
      .clk(clk), .rst(rst), .talkieState(talkieState), .currentEffect(currentEffect),
      .i2cState(i2cState), .ready(ready), .commsError(commsError), .nibble(nibble),
      .screenSel(screenSel), .initSel(initSel), .nibbleIdx(nibbleIdx), .trans(trans),
      .lcdByte(lcdByte)
   );

   lcdMessageRom lcdMessageRom_inst (
      .screenSel(screenSel), .initSel(initSel), .nibbleIdx(nibbleIdx), .nibble(nibble)
   );

   i2cByteMaster i2cByteMaster_inst (
      .clk(clk), .rst(rst), .trans(trans), .lcdByte(lcdByte), .sdaIn(sdaIn), .scl(scl),
      .sdaLow(sdaLow), .i2cState(i2cState), .ready(ready), .commsError(commsError)
   );

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module walkieDisplayTb -f src.f -o walkieDisplaySim

./obj_dir/walkieDisplaySim

/* src.f */
logic/displayPkg.sv
logic/lcdMessageRom.sv
logic/i2cByteMaster.sv
logic/lcdDisplayCtrl.sv
logic/walkieDisplay.sv
verif/walkieDisplayProperties.sv
verif/walkieDisplayTb.sv

/* verif/walkieDisplayProperties.sv */
`timescale 1ns/1ns
module walkieDisplayProperties
   import displayPkg::*;
(
   input logic clk,
   input logic rst,
   input logic trans, // Controller holds the bus
   input logic [2:0] i2cState,
   input logic ready,
   input logic commsError,
   input lcdByte_u lcdByte
);

   // A transfer only begins on an idle bus
   transStartsIdle: assert property (@(posedge clk) disable iff (rst)
      $rose(trans) |-> i2cState == i2cOff)
      else $error("trans rose while the I2C master was not idle");

   // Master answers come one at a time and only inside a transfer
   pulsesExclusive: assert property (@(posedge clk) disable iff (rst)
      (ready || commsError) |-> trans && !(ready && commsError))
      else $error("ready or commsError was out of place");

   errorDropsTrans: assert property (@(posedge clk) disable iff (rst)
      commsError |=> !trans)
      else $error("trans stayed high after commsError");

   // Backlight and enable go with every byte sent to the backpack, R/W stays low
   byteStrobes: assert property (@(posedge clk) disable iff (rst)
      trans |-> lcdByte.pins.led && lcdByte.pins.en && !lcdByte.pins.rw)
      else $error("lcdByte had led or en low or rw high during a transfer");

endmodule

bind lcdDisplayCtrl walkieDisplayProperties walkieDisplayProperties_inst (
   .clk(clk), .rst(rst), .trans(trans), .i2cState(i2cState), .ready(ready),
   .commsError(commsError), .lcdByte(lcdByte)
);

/* verif/walkieDisplayTb.sv */
`timescale 1ns/1ns
module walkieDisplayTb
   import displayPkg::*;
();

   localparam int byteCycles = 9 * 2 * sclHalfCycles + 1; // Nine SCL periods and the wait cycle
   localparam int cycleLimit = 12 * (maxNibbles + 2) * byteCycles + 8000; // Twelve messages and gaps

   logic clk = 1'b0;
   logic rst;
   logic talkieState;
   logic [2:0] currentEffect;
   logic scl;
   logic sdaLow;
   logic sdaIn;
   logic slavePull = 1'b0; // Slave side of the open-drain SDA
   logic prevScl = 1'b1;
   logic prevSda = 1'b1;
   logic inFrame = 1'b0; // Between START and STOP
   logic ackClock = 1'b0; // Ninth SCL period of a byte
   logic addrPhase = 1'b0; // Next byte is the address
   logic [7:0] shifter;
   int bitCnt;
   int dataCnt; // Data bytes seen in this transaction
   int nackAt = 0; // Data byte number that gets a NACK, zero arms nothing
   int startCount = 0;
   int txCount = 0; // Transactions closed by STOP
   lcdByte_u txRaw [0:31][0:31]; // Acknowledged data bytes of each transaction
   int txLen [0:31];
   int seenTx = 0; // Transactions already checked
   logic [5:0] expNib [0:31];
   int expLen;
   int cycleCount = 0;
   string curTest = "reset";

   assign sdaIn = !(sdaLow || slavePull); // Pull-up wins unless a side drives low

   walkieDisplay walkieDisplay_inst (
      .clk(clk), .rst(rst), .talkieState(talkieState), .currentEffect(currentEffect),
      .sdaIn(sdaIn), .scl(scl), .sdaLow(sdaLow)
   );

   always #10 clk = ~clk;

   // I2C slave, sampled on the falling clock edge where the bus lines are stable
   always @(negedge clk) begin
      if (!rst) begin
         if (prevScl && scl && prevSda && !sdaIn) begin
            inFrame = 1'b1; // START
            addrPhase = 1'b1;
            ackClock = 1'b0;
            bitCnt = 0;
            dataCnt = 0;
            txLen[txCount] = 0;
            startCount++;
         end else if (inFrame && prevScl && scl && !prevSda && sdaIn) begin
            inFrame = 1'b0; // STOP closes the transaction
            txCount++;
         end else if (inFrame && !prevScl && scl && !ackClock) begin
            shifter = {shifter[6:0], sdaIn}; // MSB first
            bitCnt++;
         end else if (inFrame && prevScl && !scl) begin
            if (ackClock) begin
               slavePull = 1'b0; // Hand SDA back after the ninth clock
               ackClock = 1'b0;
               bitCnt = 0;
            end else if (bitCnt == 8) begin
               ackClock = 1'b1;
               slavePull = 1'b1;
               if (addrPhase) begin
                  addrPhase = 1'b0;
                  if (shifter != {lcdI2cAddr, 1'b0}) begin
                     $display("Slave was addressed with %h instead of a write to %h", shifter,
                        lcdI2cAddr);
                     stopRun();
                  end
               end else begin
                  dataCnt++;
                  if (dataCnt == nackAt) begin
                     slavePull = 1'b0; // Armed NACK
                  end else begin
                     txRaw[txCount][txLen[txCount]].raw = shifter;
                     txLen[txCount]++;
                  end
               end
            end
         end
         prevScl = scl;
         prevSda = sdaIn;
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout after %0d cycles, the DUT never finished its transfers", cycleCount);
         stopRun();
      end
   end

   task automatic stopRun();
      $display("Finished with errors");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic checkNibble(input logic [5:0] expected, input logic [5:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s nibble: expected %h, actual %h", curTest, expected, actual);
         stopRun();
      end
   endtask

   task automatic checkScreenBytes(input int expected, input int actual);
      if (actual != expected) begin
         $display("FAIL %s count: expected %0d, actual %0d", curTest, expected, actual);
         stopRun();
      end
   endtask

   task automatic checkPins(input lcdByte_u expected, input lcdByte_u actual);
      if (actual.raw !== expected.raw) begin
         $display("FAIL %s pins: expected %h, actual %h", curTest, expected.raw, actual.raw);
         stopRun();
      end
   endtask

   task automatic checkBusLine(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAIL %s %s: expected %b, actual %b", curTest, name, expected, actual);
         stopRun();
      end
   endtask

   // Expected nibbles from the LCD instruction bytes and the ASCII text of the screen
   task automatic buildExpected(input logic [2:0] screen, input logic withInit);
      logic [7:0] cmds [0:5];
      logic [7:0] ch;
      string text;
      cmds = '{8'h20, 8'h28, 8'h0E, 8'h01, 8'h06, 8'h02}; // Init head, then clear, entry, home
      case (screen)
         screenNormal: text = "NORMAL";
         screenEcho: text = "ECHO";
         screenTremolo: text = "TREMOLO";
         screenReverb: text = "REVERB";
         screenSoft: text = "SOFT_CLIPPING";
         screenListen: text = "LISTENING";
         default: text = "";
      endcase
      expLen = 0;
      for (int i = withInit ? 0 : 3; i < 6; i++) begin
         expNib[expLen] = {cmds[i][7:4], 2'b00}; // High half first, rs low
         expNib[expLen + 1] = {cmds[i][3:0], 2'b00};
         expLen += 2;
      end
      for (int i = 0; i < text.len() && !withInit; i++) begin
         ch = text[i];
         expNib[expLen] = {ch[7:4], 2'b01}; // Characters go with rs high
         expNib[expLen + 1] = {ch[3:0], 2'b01};
         expLen += 2;
      end
   endtask

   // Waits for the next closed transaction and compares it with the message of screen
   task automatic takeMessage(input logic [2:0] screen, input logic withInit);
      lcdByte_u expByte;
      int idx;
      while (txCount <= seenTx) @(posedge clk);
      idx = seenTx;
      seenTx++;
      buildExpected(screen, withInit);
      checkScreenBytes(expLen, txLen[idx]);
      for (int i = 0; i < expLen; i++) begin
         expByte.pins = '{data: expNib[i][5:2], led: 1'b1, en: 1'b1, rw: 1'b0,
            rs: expNib[i][0]};
         checkNibble(expNib[i], {txRaw[idx][i].pins.data, txRaw[idx][i].pins.rw,
            txRaw[idx][i].pins.rs});
         checkPins(expByte, txRaw[idx][i]);
      end
   endtask

   task automatic expectQuiet();
      repeat (400) @(posedge clk); // Far longer than the gap before a new START
      checkScreenBytes(seenTx, startCount);
   endtask

   task automatic testInit();
      curTest = "testInit";
      checkBusLine("scl", 1'b1, scl); // Both lines released while reset holds
      checkBusLine("sdaLow", 1'b0, sdaLow);
      takeMessage(screenNone, 1'b1); // Power-up sequence comes first
      takeMessage(screenListen, 1'b0); // Then the screen for the inputs held in reset
      expectQuiet();
   endtask

   task automatic testEffects();
      logic [2:0] order [0:4];
      logic [2:0] tmp;
      int j;
      curTest = "testEffects";
      for (int i = 0; i < 5; i++) order[i] = 3'(i);
      for (int i = 4; i > 0; i--) begin
         j = $urandom % (i + 1); // Shuffle the effects
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
         talkieState <= talkTalk;
         currentEffect <= order[i];
         takeMessage(order[i], 1'b0);
         expectQuiet();
      end
   endtask

   task automatic testListen();
      curTest = "testListen";
      @(posedge clk);
      talkieState <= talkListen;
      takeMessage(screenListen, 1'b0);
      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
         currentEffect <= 3'(i); // Ignored while receiving
         repeat (20) @(posedge clk);
      end
      expectQuiet();
   endtask

   task automatic testNackRetry();
      curTest = "testNackRetry";
      nackAt = 3;
      @(posedge clk);
      talkieState <= talkTalk;
      currentEffect <= screenReverb;
      while (txCount <= seenTx) @(posedge clk);
      buildExpected(screenReverb, 1'b0);
      checkScreenBytes(2, txLen[seenTx]); // Two bytes got through before the NACK
      checkNibble(expNib[0], {txRaw[seenTx][0].pins.data, txRaw[seenTx][0].pins.rw,
         txRaw[seenTx][0].pins.rs});
      checkNibble(expNib[1], {txRaw[seenTx][1].pins.data, txRaw[seenTx][1].pins.rw,
         txRaw[seenTx][1].pins.rs});
      seenTx++;
      nackAt = 0;
      takeMessage(screenReverb, 1'b0); // Whole message again
      expectQuiet();
   endtask

   task automatic testChangeDuringSend();
      curTest = "testChangeDuringSend";
      @(posedge clk);
      currentEffect <= screenSoft;
      while (startCount <= seenTx) @(posedge clk);
      repeat (300) @(posedge clk); // Well inside the 32-byte message
      currentEffect <= screenEcho;
      takeMessage(screenSoft, 1'b0);
      takeMessage(screenEcho, 1'b0);
      expectQuiet();
   endtask

   initial begin
      void'($urandom(84));
      rst = 1'b1;
      talkieState = talkListen;
      currentEffect = screenNormal;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      testInit();
      testEffects();
      testListen();
      testNackRetry();
      testChangeDuringSend();
      $display("Finished with no errors");
      $finish;
   end

endmodule
